// ==== src/hub_consts.svh ====
// Peripheral hub constants: bus widths, device map and timer register offsets
`ifndef HUB_CONSTS_SVH
`define HUB_CONSTS_SVH

// Bus geometry
`define HUB_DATA_W      32
`define HUB_STRB_W      4

// Device map
`define HUB_TIMER_BASE  32'h8001_0000
`define HUB_TIMER_SIZE  32
`define HUB_APB_BASE    32'h8005_0000
`define HUB_APB_SIZE    65536
`define HUB_APB_ADDR_W  12

// Machine timer register offsets in bytes
`define HUB_TMR_CTRL    0
`define HUB_TMR_TIME_LO 4
`define HUB_TMR_TIME_HI 8
`define HUB_TMR_CMP_LO  12
`define HUB_TMR_CMP_HI  16

`endif

// ==== src/hub_pkg.sv ====
// Shared types for the peripheral hub bus and its device decoder
`include "hub_consts.svh"

package hub_pkg;

  // ------------------------------
  // Bus payload types
  // ------------------------------

  // One bus word
  typedef logic [`HUB_DATA_W-1:0] word_t;

  // One strobe bit per byte lane
  typedef logic [`HUB_STRB_W-1:0] strobe_t;

  // ------------------------------
  // Decoder targets
  // ------------------------------

  // DEV_NONE covers every address outside the device map
  typedef enum logic [1:0] {
    DEV_NONE,
    DEV_TIMER,
    DEV_APB
  } dev_sel_t;

endpackage

// ==== src/hub_bus_if.sv ====
// Request/response strobe bus between the hub decoder and one device
`timescale 1ns/1ps

interface hub_bus_if;

  // Request side, valid in the cycle of the request strobe
  hub_pkg::word_t   address;
  hub_pkg::word_t   write_data;
  hub_pkg::strobe_t write_strobe;
  logic             read_request;
  logic             write_request;

  // Response side, read data valid with the read response
  hub_pkg::word_t   read_data;
  logic             read_response;
  logic             write_response;

  modport manager (
    output address, write_data, write_strobe, read_request, write_request,
    input  read_data, read_response, write_response
  );

  modport device (
    input  address, write_data, write_strobe, read_request, write_request,
    output read_data, read_response, write_response
  );

endinterface

// ==== src/hub_decoder.sv ====
// Hub address decoder: routes requests to one device and muxes the responses back
`timescale 1ns/1ps
`include "hub_consts.svh"

module hub_decoder (
  input  logic              clock,
  input  logic              reset,
  input  hub_pkg::word_t    bus_address_i,
  input  hub_pkg::word_t    bus_write_data_i,
  input  hub_pkg::strobe_t  bus_write_strobe_i,
  input  logic              bus_read_request_i,
  input  logic              bus_write_request_i,
  output hub_pkg::word_t    bus_read_data_o,
  output logic              bus_read_response_o,
  output logic              bus_write_response_o,
  hub_bus_if.manager        timer_bus,
  hub_bus_if.manager        apb_bus
);

  localparam hub_pkg::word_t TIMER_BASE = `HUB_TIMER_BASE;
  localparam hub_pkg::word_t TIMER_END  = `HUB_TIMER_BASE + `HUB_TIMER_SIZE;
  localparam hub_pkg::word_t APB_BASE   = `HUB_APB_BASE;
  localparam hub_pkg::word_t APB_END    = `HUB_APB_BASE + `HUB_APB_SIZE;

  hub_pkg::dev_sel_t dev_sel;
  logic              none_read_response;
  logic              none_write_response;

  // ------------------------------
  // Address decode
  // ------------------------------

  always_comb begin
    if (bus_address_i >= TIMER_BASE && bus_address_i < TIMER_END) begin
      dev_sel = hub_pkg::DEV_TIMER;
    end else if (bus_address_i >= APB_BASE && bus_address_i < APB_END) begin
      dev_sel = hub_pkg::DEV_APB;
    end else begin
      dev_sel = hub_pkg::DEV_NONE;
    end
  end

  // Payload goes to every device, strobes only to the selected one
  assign timer_bus.address       = bus_address_i;
  assign timer_bus.write_data    = bus_write_data_i;
  assign timer_bus.write_strobe  = bus_write_strobe_i;
  assign timer_bus.read_request  = bus_read_request_i && (dev_sel == hub_pkg::DEV_TIMER);
  assign timer_bus.write_request = bus_write_request_i && (dev_sel == hub_pkg::DEV_TIMER);

  assign apb_bus.address         = bus_address_i;
  assign apb_bus.write_data      = bus_write_data_i;
  assign apb_bus.write_strobe    = bus_write_strobe_i;
  assign apb_bus.read_request    = bus_read_request_i && (dev_sel == hub_pkg::DEV_APB);
  assign apb_bus.write_request   = bus_write_request_i && (dev_sel == hub_pkg::DEV_APB);

  // ------------------------------
  // Unmapped address responder
  // ------------------------------

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      none_read_response  <= 1'b0;
      none_write_response <= 1'b0;
    end else begin
      none_read_response  <= bus_read_request_i && (dev_sel == hub_pkg::DEV_NONE);
      none_write_response <= bus_write_request_i && (dev_sel == hub_pkg::DEV_NONE);
    end
  end

  // Response mux, zero data when no device answers
  always_comb begin
    if (timer_bus.read_response) begin
      bus_read_data_o = timer_bus.read_data;
    end else if (apb_bus.read_response) begin
      bus_read_data_o = apb_bus.read_data;
    end else begin
      bus_read_data_o = '0;
    end
  end

  assign bus_read_response_o  = timer_bus.read_response | apb_bus.read_response |
                                none_read_response;
  assign bus_write_response_o = timer_bus.write_response | apb_bus.write_response |
                                none_write_response;

endmodule

// ==== src/apb_bridge.sv ====
// Bridge from the hub request bus to an APB target, with interrupt pending latch
`timescale 1ns/1ps
`include "hub_consts.svh"

module apb_bridge (
  input  logic                       clock,
  input  logic                       reset,
  hub_bus_if.device                  bus,
  output logic [`HUB_APB_ADDR_W-1:0] paddr_o,
  output logic                       psel_o,
  output logic                       penable_o,
  output logic                       pwrite_o,
  output hub_pkg::word_t             pwdata_o,
  input  hub_pkg::word_t             prdata_i,
  input  logic                       pready_i,
  input  logic                       apb_irq_i,
  input  logic                       irq_response_i,
  output logic                       irq_o
);

  typedef enum logic [1:0] {
    IDLE,
    SEL,
    ENABLE
  } apb_state_t;

  apb_state_t state;
  logic       request;
  logic       transfer_done;
  logic       apb_irq_prev;
  logic       irq_pending;

  assign request       = bus.read_request | bus.write_request;
  assign transfer_done = (state == ENABLE) && pready_i;

  // ------------------------------
  // APB state machine
  // ------------------------------

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      state <= IDLE;
    end else begin
      case (state)
        IDLE:    if (request) state <= SEL;
        SEL:     state <= ENABLE;
        ENABLE:  if (pready_i) state <= IDLE;
        default: state <= IDLE;
      endcase
    end
  end

  // Address and data held for the whole transfer
  always_ff @(posedge clock) begin
    if (state == IDLE && request) begin
      paddr_o  <= bus.address[`HUB_APB_ADDR_W-1:0];
      pwdata_o <= bus.write_data;
    end
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      pwrite_o <= 1'b0;
    end else if (state == IDLE && request) begin
      pwrite_o <= bus.write_request;
    end
  end

  assign psel_o    = (state != IDLE);
  assign penable_o = (state == ENABLE);

  // Response on the cycle pready is seen in ENABLE
  assign bus.read_data      = prdata_i;
  assign bus.read_response  = transfer_done && !pwrite_o;
  assign bus.write_response = transfer_done && pwrite_o;

  // ------------------------------
  // Interrupt pending latch
  // ------------------------------

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      apb_irq_prev <= 1'b0;
      irq_pending  <= 1'b0;
    end else begin
      apb_irq_prev <= apb_irq_i;
      // A new rising edge wins over a clear in the same cycle
      if (apb_irq_i && !apb_irq_prev) begin
        irq_pending <= 1'b1;
      end else if (irq_response_i) begin
        irq_pending <= 1'b0;
      end
    end
  end

  assign irq_o = irq_pending;

endmodule

// ==== src/machine_timer.sv ====
// Machine timer: 64-bit counter with compare register and level interrupt
`timescale 1ns/1ps
`include "hub_consts.svh"

module machine_timer (
  input  logic      clock,
  input  logic      reset,
  hub_bus_if.device bus,
  output logic      irq_o
);

  localparam int OFF_W = $clog2(`HUB_TIMER_SIZE);

  logic [OFF_W-1:0] offset;
  logic             enable;
  logic [63:0]      count;
  logic [63:0]      compare;
  hub_pkg::word_t   read_word;
  logic             wr_ctrl;
  logic             wr_time_lo;
  logic             wr_time_hi;
  logic             wr_cmp_lo;
  logic             wr_cmp_hi;

  // Replace only the byte lanes with a strobe set
  function automatic hub_pkg::word_t merge_bytes(input hub_pkg::word_t old_word,
                                                 input hub_pkg::word_t new_word,
                                                 input hub_pkg::strobe_t strobe);
    hub_pkg::word_t result;
    result = old_word;
    for (int i = 0; i < `HUB_STRB_W; i++) begin
      if (strobe[i]) result[8*i +: 8] = new_word[8*i +: 8];
    end
    return result;
  endfunction

  assign offset     = bus.address[OFF_W-1:0];
  assign wr_ctrl    = bus.write_request && (offset == OFF_W'(`HUB_TMR_CTRL));
  assign wr_time_lo = bus.write_request && (offset == OFF_W'(`HUB_TMR_TIME_LO));
  assign wr_time_hi = bus.write_request && (offset == OFF_W'(`HUB_TMR_TIME_HI));
  assign wr_cmp_lo  = bus.write_request && (offset == OFF_W'(`HUB_TMR_CMP_LO));
  assign wr_cmp_hi  = bus.write_request && (offset == OFF_W'(`HUB_TMR_CMP_HI));

  // ------------------------------
  // Registers and counter
  // ------------------------------

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      enable  <= 1'b0;
      count   <= '0;
      compare <= '1;
    end else begin
      if (wr_ctrl && bus.write_strobe[0]) enable <= bus.write_data[0];
      // A software write to the count takes priority over the increment
      if (wr_time_lo || wr_time_hi) begin
        if (wr_time_lo) count[31:0]  <= merge_bytes(count[31:0], bus.write_data,
                                                     bus.write_strobe);
        if (wr_time_hi) count[63:32] <= merge_bytes(count[63:32], bus.write_data,
                                                    bus.write_strobe);
      end else if (enable) begin
        count <= count + 64'd1;
      end
      if (wr_cmp_lo) compare[31:0]  <= merge_bytes(compare[31:0], bus.write_data,
                                                   bus.write_strobe);
      if (wr_cmp_hi) compare[63:32] <= merge_bytes(compare[63:32], bus.write_data,
                                                   bus.write_strobe);
    end
  end

  // ------------------------------
  // Read path, one cycle latency
  // ------------------------------

  always_comb begin
    case (offset)
      OFF_W'(`HUB_TMR_CTRL):    read_word = hub_pkg::word_t'(enable);
      OFF_W'(`HUB_TMR_TIME_LO): read_word = count[31:0];
      OFF_W'(`HUB_TMR_TIME_HI): read_word = count[63:32];
      OFF_W'(`HUB_TMR_CMP_LO):  read_word = compare[31:0];
      OFF_W'(`HUB_TMR_CMP_HI):  read_word = compare[63:32];
      default:                  read_word = '0;
    endcase
  end

  always_ff @(posedge clock) begin
    if (bus.read_request) bus.read_data <= read_word;
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      bus.read_response  <= 1'b0;
      bus.write_response <= 1'b0;
    end else begin
      bus.read_response  <= bus.read_request;
      bus.write_response <= bus.write_request;
    end
  end

  assign irq_o = enable && (count >= compare);

endmodule

// ==== src/periph_hub.sv ====
// Peripheral hub top: address decoder, machine timer and APB bridge
`timescale 1ns/1ps
`include "hub_consts.svh"

module periph_hub (
  input  logic                       clock,
  input  logic                       reset,

  // Manager request/response bus
  input  hub_pkg::word_t             bus_address_i,
  input  hub_pkg::word_t             bus_write_data_i,
  input  hub_pkg::strobe_t           bus_write_strobe_i,
  input  logic                       bus_read_request_i,
  input  logic                       bus_write_request_i,
  output hub_pkg::word_t             bus_read_data_o,
  output logic                       bus_read_response_o,
  output logic                       bus_write_response_o,

  // APB manager port
  output logic [`HUB_APB_ADDR_W-1:0] paddr_o,
  output logic                       psel_o,
  output logic                       penable_o,
  output logic                       pwrite_o,
  output hub_pkg::word_t             pwdata_o,
  input  hub_pkg::word_t             prdata_i,
  input  logic                       pready_i,

  // Interrupts
  input  logic                       apb_irq_i,
  input  logic                       irq_apb_response_i,
  output logic                       irq_apb_o,
  output logic                       irq_timer_o
);

  hub_bus_if timer_bus ();
  hub_bus_if apb_bus ();

  hub_decoder u_decoder (
    .clock                (clock),
    .reset                (reset),
    .bus_address_i        (bus_address_i),
    .bus_write_data_i     (bus_write_data_i),
    .bus_write_strobe_i   (bus_write_strobe_i),
    .bus_read_request_i   (bus_read_request_i),
    .bus_write_request_i  (bus_write_request_i),
    .bus_read_data_o      (bus_read_data_o),
    .bus_read_response_o  (bus_read_response_o),
    .bus_write_response_o (bus_write_response_o),
    .timer_bus            (timer_bus.manager),
    .apb_bus              (apb_bus.manager)
  );

  machine_timer u_timer (
    .clock (clock),
    .reset (reset),
    .bus   (timer_bus.device),
    .irq_o (irq_timer_o)
  );

  apb_bridge u_bridge (
    .clock          (clock),
    .reset          (reset),
    .bus            (apb_bus.device),
    .paddr_o        (paddr_o),
    .psel_o         (psel_o),
    .penable_o      (penable_o),
    .pwrite_o       (pwrite_o),
    .pwdata_o       (pwdata_o),
    .prdata_i       (prdata_i),
    .pready_i       (pready_i),
    .apb_irq_i      (apb_irq_i),
    .irq_response_i (irq_apb_response_i),
    .irq_o          (irq_apb_o)
  );

endmodule

// ==== verification/periph_hub_asserts.sv ====
// Protocol checks for the hub request bus timing and the APB manager port
`timescale 1ns/1ps
`include "hub_consts.svh"

module periph_hub_asserts (
  input logic                       clock,
  input logic                       reset,
  input hub_pkg::word_t             address_i,
  input logic                       read_request_i,
  input logic                       write_request_i,
  input logic                       read_response_i,
  input logic                       write_response_i,
  input logic [`HUB_APB_ADDR_W-1:0] paddr_i,
  input logic                       psel_i,
  input logic                       penable_i,
  input logic                       pwrite_i,
  input logic                       pready_i
);

  int   fail_count = 0;
  logic timer_hit;

  assign timer_hit = (address_i >= `HUB_TIMER_BASE) &&
                     (address_i < `HUB_TIMER_BASE + `HUB_TIMER_SIZE);

  // ------------------------------
  // Timer answers one cycle later
  // ------------------------------

  timer_read_latency: assert property (@(posedge clock) disable iff (reset)
    read_request_i && timer_hit |=> read_response_i)
    else begin
      fail_count++;
      $error("Timer read response did not follow its request by one cycle");
    end

  timer_write_latency: assert property (@(posedge clock) disable iff (reset)
    write_request_i && timer_hit |=> write_response_i)
    else begin
      fail_count++;
      $error("Timer write response did not follow its request by one cycle");
    end

  // ------------------------------
  // APB phases
  // ------------------------------

  penable_needs_psel: assert property (@(posedge clock) disable iff (reset)
    penable_i |-> psel_i)
    else begin
      fail_count++;
      $error("penable high without psel");
    end

  setup_before_enable: assert property (@(posedge clock) disable iff (reset)
    $rose(penable_i) |-> $past(psel_i))
    else begin
      fail_count++;
      $error("penable rose without a setup cycle with psel");
    end

  // Address and direction frozen from setup to the end of the transfer
  paddr_stable: assert property (@(posedge clock) disable iff (reset)
    penable_i |-> $stable(paddr_i) && $stable(pwrite_i))
    else begin
      fail_count++;
      $error("paddr or pwrite changed during an APB transfer");
    end

  write_response_on_pready: assert property (@(posedge clock) disable iff (reset)
    psel_i && penable_i && pready_i && pwrite_i |-> write_response_i)
    else begin
      fail_count++;
      $error("No write response in the cycle pready completed an APB write");
    end

  single_write_response: assert property (@(posedge clock) disable iff (reset)
    write_response_i |=> !write_response_i)
    else begin
      fail_count++;
      $error("Write response lasted more than one cycle");
    end

endmodule

bind periph_hub periph_hub_asserts u_asserts (
  .clock            (clock),
  .reset            (reset),
  .address_i        (bus_address_i),
  .read_request_i   (bus_read_request_i),
  .write_request_i  (bus_write_request_i),
  .read_response_i  (bus_read_response_o),
  .write_response_i (bus_write_response_o),
  .paddr_i          (paddr_o),
  .psel_i           (psel_o),
  .penable_i        (penable_o),
  .pwrite_i         (pwrite_o),
  .pready_i         (pready_i)
);

// ==== verification/periph_hub_tb.sv ====
// Testbench for the peripheral hub with bus stimulus, APB target model and value checks
`timescale 1ns/1ps
`include "hub_consts.svh"

module periph_hub_tb;

  localparam int RESPONSE_TIMEOUT = 20;

  logic                       clock;
  logic                       reset;
  hub_pkg::word_t             bus_address;
  hub_pkg::word_t             bus_write_data;
  hub_pkg::strobe_t           bus_write_strobe;
  logic                       bus_read_request;
  logic                       bus_write_request;
  hub_pkg::word_t             bus_read_data;
  logic                       bus_read_response;
  logic                       bus_write_response;
  logic [`HUB_APB_ADDR_W-1:0] paddr;
  logic                       psel;
  logic                       penable;
  logic                       pwrite;
  hub_pkg::word_t             pwdata;
  hub_pkg::word_t             prdata;
  logic                       pready;
  logic                       apb_irq;
  logic                       irq_apb_response;
  logic                       irq_apb;
  logic                       irq_timer;

  integer                     seed;
  int                         wait_left;
  int                         apb_write_count;
  int                         writes_before;
  int                         latency;
  logic [`HUB_APB_ADDR_W-1:0] apb_write_addr;
  hub_pkg::word_t             apb_write_data;
  hub_pkg::word_t             read_value;
  hub_pkg::word_t             first_count;
  hub_pkg::word_t             apb_offset;

  periph_hub UUT (
    .clock                (clock),
    .reset                (reset),
    .bus_address_i        (bus_address),
    .bus_write_data_i     (bus_write_data),
    .bus_write_strobe_i   (bus_write_strobe),
    .bus_read_request_i   (bus_read_request),
    .bus_write_request_i  (bus_write_request),
    .bus_read_data_o      (bus_read_data),
    .bus_read_response_o  (bus_read_response),
    .bus_write_response_o (bus_write_response),
    .paddr_o              (paddr),
    .psel_o               (psel),
    .penable_o            (penable),
    .pwrite_o             (pwrite),
    .pwdata_o             (pwdata),
    .prdata_i             (prdata),
    .pready_i             (pready),
    .apb_irq_i            (apb_irq),
    .irq_apb_response_i   (irq_apb_response),
    .irq_apb_o            (irq_apb),
    .irq_timer_o          (irq_timer)
  );

  always #20 clock = ~clock;

  // Read word the APB target returns for an address
  function automatic hub_pkg::word_t target_word(input logic [`HUB_APB_ADDR_W-1:0] addr);
    return {8'hA5, 12'h3C0, addr};
  endfunction

  // ------------------------------
  // APB target model
  // ------------------------------

  always @(negedge clock) begin
    if (psel && !penable) begin
      wait_left = $random(seed) & 3;
      pready    = (wait_left == 0);
      prdata    = target_word(paddr);
    end else if (psel && penable && !pready) begin
      wait_left = wait_left - 1;
      pready    = (wait_left == 0);
    end else if (!psel) begin
      pready = 1'b0;
    end
    // This write completes at the next rising edge
    if (psel && penable && pready && pwrite) begin
      apb_write_addr  = paddr;
      apb_write_data  = pwdata;
      apb_write_count = apb_write_count + 1;
    end
  end

  // A failed protocol assertion ends the run
  always @(negedge clock) begin
    if (UUT.u_asserts.fail_count != 0) begin
      $display("Test failed");
      $fatal(1, "A protocol assertion failed");
    end
  end

  task automatic check_value(input string name, input hub_pkg::word_t expected,
                             input hub_pkg::word_t actual);
    if (expected !== actual) begin
      $display("Fail %s: expected %h, actual %h", name, expected, actual);
      $display("Test failed");
      $fatal(1, "Value mismatch");
    end
  endtask

  task automatic check_above(input string name, input hub_pkg::word_t floor_value,
                             input hub_pkg::word_t actual);
    if (!(actual > floor_value)) begin
      $display("Fail %s: expected above %h, actual %h", name, floor_value, actual);
      $display("Test failed");
      $fatal(1, "Value mismatch");
    end
  endtask

  // One request strobe followed by a wait for the matching response
  task automatic bus_access(input logic is_write, input hub_pkg::word_t addr,
                            input hub_pkg::word_t wdata, output hub_pkg::word_t rdata,
                            output int cycles);
    logic got;
    @(negedge clock);
    bus_address       = addr;
    bus_write_data    = wdata;
    bus_read_request  = !is_write;
    bus_write_request = is_write;
    @(negedge clock);
    bus_read_request  = 1'b0;
    bus_write_request = 1'b0;
    cycles = 0;
    got    = 1'b0;
    // Responses sampled at the rising edge ahead of the register updates
    while (!got && cycles < RESPONSE_TIMEOUT) begin
      @(posedge clock);
      cycles = cycles + 1;
      got    = is_write ? bus_write_response : bus_read_response;
    end
    if (!got) begin
      $display("No response from the hub within %0d cycles for address %h",
               RESPONSE_TIMEOUT, addr);
      $display("Test failed");
      $fatal(1, "Response timeout");
    end else begin
      rdata = bus_read_data;
    end
  endtask

  task automatic write_word(input hub_pkg::word_t addr, input hub_pkg::word_t data);
    hub_pkg::word_t unused_data;
    int             unused_cycles;
    bus_access(1'b1, addr, data, unused_data, unused_cycles);
  endtask

  task automatic read_word(input hub_pkg::word_t addr, output hub_pkg::word_t data,
                           output int cycles);
    bus_access(1'b0, addr, 32'd0, data, cycles);
  endtask

  initial begin
    clock             = 1'b0;
    reset             = 1'b1;
    seed              = 38554;
    bus_address       = '0;
    bus_write_data    = '0;
    bus_write_strobe  = 4'hF;
    bus_read_request  = 1'b0;
    bus_write_request = 1'b0;
    prdata            = '0;
    pready            = 1'b0;
    apb_irq           = 1'b0;
    irq_apb_response  = 1'b0;
    wait_left         = 0;
    apb_write_count   = 0;
    apb_write_addr    = '0;
    apb_write_data    = '0;
    repeat (16) @(negedge clock);
    reset = 1'b0;
    check_value("reset timer irq", 32'd0, {31'd0, irq_timer});

    // Timer compare readback
    write_word(`HUB_TIMER_BASE + `HUB_TMR_CMP_LO, 32'h1234_5678);
    read_word(`HUB_TIMER_BASE + `HUB_TMR_CMP_LO, read_value, latency);
    check_value("timer compare readback", 32'h1234_5678, read_value);
    check_value("timer read latency", 32'd1, latency);

    // Running count and compare interrupt
    write_word(`HUB_TIMER_BASE + `HUB_TMR_CTRL, 32'd1);
    read_word(`HUB_TIMER_BASE + `HUB_TMR_TIME_LO, first_count, latency);
    read_word(`HUB_TIMER_BASE + `HUB_TMR_TIME_LO, read_value, latency);
    check_above("timer count increases", first_count, read_value);
    write_word(`HUB_TIMER_BASE + `HUB_TMR_CMP_HI, 32'd0);
    @(negedge clock);
    check_value("timer irq low below compare", 32'd0, {31'd0, irq_timer});
    write_word(`HUB_TIMER_BASE + `HUB_TMR_CMP_LO, 32'd2);
    @(negedge clock);
    check_value("timer irq raised", 32'd1, {31'd0, irq_timer});
    write_word(`HUB_TIMER_BASE + `HUB_TMR_CTRL, 32'd0);
    @(negedge clock);
    check_value("timer irq dropped", 32'd0, {31'd0, irq_timer});

    // APB reads at random word offsets
    repeat (4) begin
      apb_offset = $random(seed) & 32'h0000_0FFC;
      read_word(`HUB_APB_BASE + apb_offset, read_value, latency);
      check_value("apb read", target_word(apb_offset[`HUB_APB_ADDR_W-1:0]), read_value);
      check_above("apb read latency", 32'd1, latency);
    end

    // APB write
    writes_before = apb_write_count;
    write_word(`HUB_APB_BASE + 32'h2A8, 32'hCAFE_F00D);
    check_value("apb write count", writes_before + 1, apb_write_count);
    check_value("apb write address", 32'h2A8, {20'd0, apb_write_addr});
    check_value("apb write data", 32'hCAFE_F00D, apb_write_data);

    // Interrupt pending latch
    check_value("apb irq idle", 32'd0, {31'd0, irq_apb});
    @(negedge clock);
    apb_irq = 1'b1;
    @(negedge clock);
    apb_irq = 1'b0;
    repeat (3) @(negedge clock);
    check_value("apb irq held", 32'd1, {31'd0, irq_apb});
    irq_apb_response = 1'b1;
    @(negedge clock);
    irq_apb_response = 1'b0;
    check_value("apb irq cleared", 32'd0, {31'd0, irq_apb});

    // Unmapped address
    read_word(32'h9000_0000, read_value, latency);
    check_value("unmapped read data", 32'd0, read_value);
    check_value("unmapped read latency", 32'd1, latency);

    @(negedge clock);
    if (UUT.u_asserts.fail_count == 0) begin
      $display("Test passed");
      $finish;
    end else begin
      $display("Test failed");
      $fatal(1, "A protocol assertion failed");
    end
  end

endmodule

// ==== tb.f ====
+incdir+src
src/hub_pkg.sv
src/hub_bus_if.sv
src/hub_decoder.sv
src/apb_bridge.sv
src/machine_timer.sv
src/periph_hub.sv
verification/periph_hub_asserts.sv
verification/periph_hub_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
rm -rf obj_dir sim.log
verilator --binary --assert --top-module periph_hub_tb -f tb.f -o periph_hub_sim \
  && ./obj_dir/periph_hub_sim +verilator+error+limit+100 2>&1 | tee sim.log
grep -qsx "Test passed" sim.log \
  && echo "Simulation run passed" \
  || { echo "Simulation run failed"; exit 1; }
